// File: Makefile
# Verilator build and run of the ring router testbench
VERILATOR   ?= verilator
TOP         ?= ring_router_tb
RTL_TOP     ?= ring_router
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= Result: PASSED
FAIL_MSG    ?= Result: FAILED
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0
RTL_SRCS    ?= src/router_pkg.sv src/input_port.sv src/output_port.sv \
	src/route_switch.sv src/ring_router.sv
TB_SRCS     ?= verification/ring_router_assertions.sv verification/ring_router_tb.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/$(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
		! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
src/router_pkg.sv
src/input_port.sv
src/output_port.sv
src/route_switch.sv
src/ring_router.sv
verification/ring_router_assertions.sv
verification/ring_router_tb.sv

// File: src/input_port.sv
// input_port: even and odd class buffers, flit acceptance, registered ready
`default_nettype none

module input_port (
	input  logic              clk,
	input  logic              reset,
	input  logic              polarity,
	input  router_pkg::link_t link,
	output logic              ready,
	output router_pkg::slot_t even_slot,
	output router_pkg::slot_t odd_slot,
	input  logic              free_even,
	input  logic              free_odd
);

	router_pkg::flit_t even_buf;
	router_pkg::flit_t odd_buf;
	logic              even_full;
	logic              odd_full;
	logic              accept;
	logic              even_full_next;
	logic              odd_full_next;

	assign accept = link.send && ready;

	// outside traffic: polarity 1 fills even, polarity 0 fills odd
	always_comb begin
		even_full_next = even_full;
		odd_full_next  = odd_full;
		if (accept && polarity)
			even_full_next = 1'b1;
		else if (free_even)
			even_full_next = 1'b0;  // switch took it
		if (accept && !polarity)
			odd_full_next = 1'b1;
		else if (free_odd)
			odd_full_next = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			even_full <= 1'b0;
			odd_full  <= 1'b0;
			ready     <= 1'b1;
		end else begin
			even_full <= even_full_next;
			odd_full  <= odd_full_next;
			ready     <= polarity ? !odd_full_next : !even_full_next; // next external class
		end
	end

	always_ff @(posedge clk) begin
		if (accept && polarity)
			even_buf <= link.data;
		if (accept && !polarity)
			odd_buf <= link.data;
	end

	assign even_slot = '{full: even_full, flit: even_buf};
	assign odd_slot  = '{full: odd_full, flit: odd_buf};

endmodule

`default_nettype wire

// File: src/output_port.sv
// output_port: two-way round-robin grant, hop decrement, class buffers, link send
`default_nettype none

module output_port (
	input  logic              clk,
	input  logic              reset,
	input  logic              polarity,
	input  logic              req_a,
	input  logic              req_b,
	input  router_pkg::flit_t flit_a,
	input  router_pkg::flit_t flit_b,
	input  logic              decrement_a,
	input  logic              decrement_b,
	output logic              grant_a,
	output logic              grant_b,
	input  logic              ready_in,
	output router_pkg::link_t link
);

	router_pkg::flit_t                even_buf;
	router_pkg::flit_t                odd_buf;
	logic                             even_full;
	logic                             odd_full;
	logic                             prio_b;  // 0 favors source a on a tie
	logic                             internal_full;
	logic                             external_full;
	router_pkg::flit_t                external_flit;
	logic                             tie;
	logic                             store;
	logic                             send_now;
	logic [router_pkg::hop_width-1:0] hop_dec;
	router_pkg::flit_t                granted;
	router_pkg::flit_t                stored;

	// polarity 0 routes even and sends odd, polarity 1 the other way round
	assign internal_full = polarity ? odd_full : even_full;
	assign external_full = polarity ? even_full : odd_full;
	assign external_flit = polarity ? even_buf : odd_buf;

	//////////////////////////////
	// arbitration
	//////////////////////////////

	assign tie      = req_a && req_b && !internal_full;
	assign grant_a  = req_a && !internal_full && (!req_b || !prio_b);
	assign grant_b  = req_b && !internal_full && (!req_a || prio_b);
	assign store    = grant_a || grant_b;
	assign send_now = external_full && ready_in;

	always_comb begin
		granted        = grant_a ? flit_a : flit_b;
		hop_dec        = '0;
		hop_dec[0]     = grant_a ? decrement_a : decrement_b;
		stored         = granted;
		stored.hdr.hop = granted.hdr.hop - hop_dec;  // ring hop used up
	end

	//////////////////////////////
	// buffer state and link
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			even_full <= 1'b0;
			odd_full  <= 1'b0;
			prio_b    <= 1'b0;
			link      <= '0;
		end else begin
			if (tie)
				prio_b <= !prio_b;
			if (polarity) begin
				if (store)
					odd_full <= 1'b1;
				if (send_now)
					even_full <= 1'b0;
			end else begin
				if (store)
					even_full <= 1'b1;
				if (send_now)
					odd_full <= 1'b0;
			end
			link.send <= send_now;
			link.data <= send_now ? external_flit : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (store && polarity)
			odd_buf <= stored;
		if (store && !polarity)
			even_buf <= stored;
	end

endmodule

`default_nettype wire

// File: src/ring_router.sv
// ring_router: top level, three input ports feeding the route switch
`default_nettype none

module ring_router (
	input  logic              clk,
	input  logic              reset,
	input  router_pkg::link_t cw_in,
	input  router_pkg::link_t ccw_in,
	input  router_pkg::link_t pe_in,
	output logic              cw_ready_out,
	output logic              ccw_ready_out,
	output logic              pe_ready_out,
	output router_pkg::link_t cw_out,
	output router_pkg::link_t ccw_out,
	output router_pkg::link_t pe_out,
	input  logic              cw_ready_in,
	input  logic              ccw_ready_in,
	input  logic              pe_ready_in,
	output logic              polarity
);

	router_pkg::link_t in_links [3];
	logic              ready_out [3];
	router_pkg::slot_t slots [3][2];  // [port][0 even, 1 odd]
	logic              frees [3][2];
	logic              ready_in [3];
	router_pkg::link_t out_links [3];

	assign in_links[router_pkg::port_cw]  = cw_in;
	assign in_links[router_pkg::port_ccw] = ccw_in;
	assign in_links[router_pkg::port_pe]  = pe_in;

	assign ready_in[router_pkg::port_cw]  = cw_ready_in;
	assign ready_in[router_pkg::port_ccw] = ccw_ready_in;
	assign ready_in[router_pkg::port_pe]  = pe_ready_in;

	for (genvar i = 0; i < 3; i++) begin : g_input
		input_port u_input_port (
			.clk       (clk),
			.reset     (reset),
			.polarity  (polarity),
			.link      (in_links[i]),
			.ready     (ready_out[i]),
			.even_slot (slots[i][0]),
			.odd_slot  (slots[i][1]),
			.free_even (frees[i][0]),
			.free_odd  (frees[i][1])
		);
	end

	route_switch u_route_switch (
		.clk      (clk),
		.reset    (reset),
		.slots    (slots),
		.frees    (frees),
		.ready_in (ready_in),
		.links    (out_links),
		.polarity (polarity)
	);

	assign cw_ready_out  = ready_out[router_pkg::port_cw];
	assign ccw_ready_out = ready_out[router_pkg::port_ccw];
	assign pe_ready_out  = ready_out[router_pkg::port_pe];

	assign cw_out  = out_links[router_pkg::port_cw];
	assign ccw_out = out_links[router_pkg::port_ccw];
	assign pe_out  = out_links[router_pkg::port_pe];

endmodule

`default_nettype wire

// File: src/route_switch.sv
// route_switch: polarity register, hop and dir decode, three output ports, free return
`default_nettype none

module route_switch (
	input  logic              clk,
	input  logic              reset,
	input  router_pkg::slot_t slots [3][2],
	output logic              frees [3][2],
	input  logic              ready_in [3],
	output router_pkg::link_t links [3],
	output logic              polarity
);

	router_pkg::slot_t cw_slot;
	router_pkg::slot_t ccw_slot;
	router_pkg::slot_t pe_slot;
	logic              cw_cont;   // hop nonzero, stays on the ring
	logic              ccw_cont;
	logic              pe_cont;
	logic              pe_grant_cw;
	logic              pe_grant_ccw;
	logic              cw_grant_cw;
	logic              cw_grant_pe;
	logic              ccw_grant_ccw;
	logic              ccw_grant_pe;

	always_ff @(posedge clk) begin
		if (reset)
			polarity <= 1'b0;
		else
			polarity <= !polarity;
	end

	// class index equals polarity for the internal side
	assign cw_slot  = slots[router_pkg::port_cw][polarity];
	assign ccw_slot = slots[router_pkg::port_ccw][polarity];
	assign pe_slot  = slots[router_pkg::port_pe][polarity];

	assign cw_cont  = cw_slot.flit.hdr.hop != '0;
	assign ccw_cont = ccw_slot.flit.hdr.hop != '0;
	assign pe_cont  = pe_slot.flit.hdr.hop != '0;

	//////////////////////////////
	// output ports
	//////////////////////////////

	output_port u_pe_out (
		.clk         (clk),
		.reset       (reset),
		.polarity    (polarity),
		.req_a       (cw_slot.full && !cw_cont),   // eject
		.req_b       (ccw_slot.full && !ccw_cont),
		.flit_a      (cw_slot.flit),
		.flit_b      (ccw_slot.flit),
		.decrement_a (cw_cont),
		.decrement_b (ccw_cont),
		.grant_a     (pe_grant_cw),
		.grant_b     (pe_grant_ccw),
		.ready_in    (ready_in[router_pkg::port_pe]),
		.link        (links[router_pkg::port_pe])
	);

	output_port u_cw_out (
		.clk         (clk),
		.reset       (reset),
		.polarity    (polarity),
		.req_a       (cw_slot.full && cw_cont),
		.req_b       (pe_slot.full && !pe_slot.flit.hdr.dir), // inject cw
		.flit_a      (cw_slot.flit),
		.flit_b      (pe_slot.flit),
		.decrement_a (cw_cont),
		.decrement_b (pe_cont),
		.grant_a     (cw_grant_cw),
		.grant_b     (cw_grant_pe),
		.ready_in    (ready_in[router_pkg::port_cw]),
		.link        (links[router_pkg::port_cw])
	);

	output_port u_ccw_out (
		.clk         (clk),
		.reset       (reset),
		.polarity    (polarity),
		.req_a       (ccw_slot.full && ccw_cont),
		.req_b       (pe_slot.full && pe_slot.flit.hdr.dir),  // inject ccw
		.flit_a      (ccw_slot.flit),
		.flit_b      (pe_slot.flit),
		.decrement_a (ccw_cont),
		.decrement_b (pe_cont),
		.grant_a     (ccw_grant_ccw),
		.grant_b     (ccw_grant_pe),
		.ready_in    (ready_in[router_pkg::port_ccw]),
		.link        (links[router_pkg::port_ccw])
	);

	// a flit has exactly one route, so at most one grant per input
	always_comb begin
		for (int p = 0; p < 3; p++) begin
			for (int c = 0; c < 2; c++) begin
				frees[p][c] = 1'b0;
			end
		end
		frees[router_pkg::port_cw][polarity]  = pe_grant_cw || cw_grant_cw;
		frees[router_pkg::port_ccw][polarity] = pe_grant_ccw || ccw_grant_ccw;
		frees[router_pkg::port_pe][polarity]  = cw_grant_pe || ccw_grant_pe;
	end

endmodule

`default_nettype wire

// File: src/router_pkg.sv
// flit layout, link and slot structs, port enum, widths
`default_nettype none

package router_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int flit_width = 64;
	localparam int hop_width  = 8;

	// header as seen by the switch, msb first
	typedef struct packed {
		logic                 vc;       // carried through untouched
		logic                 dir;      // 0 cw, 1 ccw
		logic [5:0]           reserved;
		logic [hop_width-1:0] hop;      // hops still to go
		logic [47:0]          payload;
	} flit_header_t;

	// ports and wires move raw, switch decodes hdr
	typedef union packed {
		logic [flit_width-1:0] raw;
		flit_header_t          hdr;
	} flit_t;

	// one direction of a link
	typedef struct packed {
		logic  send;
		flit_t data;  // zero when send is low
	} link_t;

	typedef enum logic [1:0] {
		port_cw,
		port_ccw,
		port_pe
	} port_e;

	// buffered flit waiting for the switch
	typedef struct packed {
		logic  full;
		flit_t flit;
	} slot_t;

endpackage

`default_nettype wire

// File: verification/ring_router_assertions.sv
// concurrent checks on the router outputs for idle data, quiet start and polarity toggle
`default_nettype none

module ring_router_assertions (
	input logic              clk,
	input logic              reset,
	input router_pkg::link_t cw_out,
	input router_pkg::link_t ccw_out,
	input router_pkg::link_t pe_out,
	input logic              polarity
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;  // assertion failures so far

	// an idle link carries zero data
	cw_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!cw_out.send |-> cw_out.data == '0)
	else begin
		$error("cw_out data nonzero while send is low");
		fail_count++;
	end

	ccw_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!ccw_out.send |-> ccw_out.data == '0)
	else begin
		$error("ccw_out data nonzero while send is low");
		fail_count++;
	end

	pe_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!pe_out.send |-> pe_out.data == '0)
	else begin
		$error("pe_out data nonzero while send is low");
		fail_count++;
	end

	// first edge out of reset must not launch a flit
	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |=> !(cw_out.send || ccw_out.send || pe_out.send))
	else begin
		$error("a send output is high in the first cycle after reset");
		fail_count++;
	end

	polarity_toggles: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> polarity != $past(polarity))
	else begin
		$error("polarity did not toggle");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: verification/ring_router_tb.sv
// clock, reset, watchdog, output monitor, checks and directed tests for the ring router
`default_nettype none

module ring_router_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 10;
	localparam int wait_limit   = 20;  // cycles any single flit may take
	localparam int budget_total = 10 + 100 + 100 + 100 + 200 + 150;  // cycle budgets per test

	typedef struct packed {
		logic [31:0]       stamp;  // cycle count when send was seen
		router_pkg::flit_t flit;
	} rx_t;

	logic              clk;
	logic              reset;
	router_pkg::link_t cw_in;
	router_pkg::link_t ccw_in;
	router_pkg::link_t pe_in;
	logic              cw_ready_out;
	logic              ccw_ready_out;
	logic              pe_ready_out;
	router_pkg::link_t cw_out;
	router_pkg::link_t ccw_out;
	router_pkg::link_t pe_out;
	logic              cw_ready_in;
	logic              ccw_ready_in;
	logic              pe_ready_in;
	logic              polarity;

	int unsigned cycle = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          tests = 0;
	rx_t         rx_cw [$];
	rx_t         rx_ccw [$];
	rx_t         rx_pe [$];

	ring_router UUT (
		.clk           (clk),
		.reset         (reset),
		.cw_in         (cw_in),
		.ccw_in        (ccw_in),
		.pe_in         (pe_in),
		.cw_ready_out  (cw_ready_out),
		.ccw_ready_out (ccw_ready_out),
		.pe_ready_out  (pe_ready_out),
		.cw_out        (cw_out),
		.ccw_out       (ccw_out),
		.pe_out        (pe_out),
		.cw_ready_in   (cw_ready_in),
		.ccw_ready_in  (ccw_ready_in),
		.pe_ready_in   (pe_ready_in),
		.polarity      (polarity)
	);

	bind ring_router ring_router_assertions u_assertions (
		.clk      (clk),
		.reset    (reset),
		.cw_out   (cw_out),
		.ccw_out  (ccw_out),
		.pe_out   (pe_out),
		.polarity (polarity)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic rx_t stamped(input router_pkg::flit_t flit);
		rx_t item;
		item.stamp = cycle;
		item.flit  = flit;
		return item;
	endfunction

	// everything the router sends is taken at the falling edge
	always @(negedge clk) begin
		if (cw_out.send)
			rx_cw.push_back(stamped(cw_out.data));
		if (ccw_out.send)
			rx_ccw.push_back(stamped(ccw_out.data));
		if (pe_out.send)
			rx_pe.push_back(stamped(pe_out.data));
	end

	initial begin
		#((budget_total + reset_cycles) * 10);
		$display("watchdog expired after %0d cycles, a test hung", budget_total + reset_cycles);
		$display("Result: FAILED");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic report(input string msg);
		$display("%s", msg);
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		if (rx_cw.size() + rx_ccw.size() + rx_pe.size() != 0)
			report($sformatf("%s left unexpected flits on the outputs", name));
		rx_cw.delete();
		rx_ccw.delete();
		rx_pe.delete();
		$display("test %s: %s, %0d errors", name, test_errors == 0 ? "ok" : "failed", test_errors);
		errors += test_errors;
		test_errors = 0;
		tests++;
	endtask

	task automatic drive(input router_pkg::port_e port, input router_pkg::link_t value);
		case (port)
			router_pkg::port_cw:  cw_in  = value;
			router_pkg::port_ccw: ccw_in = value;
			default:              pe_in  = value;
		endcase
	endtask

	function automatic logic ready_of(input router_pkg::port_e port);
		case (port)
			router_pkg::port_cw:  return cw_ready_out;
			router_pkg::port_ccw: return ccw_ready_out;
			default:              return pe_ready_out;
		endcase
	endfunction

	function automatic int rx_size(input router_pkg::port_e port);
		case (port)
			router_pkg::port_cw:  return rx_cw.size();
			router_pkg::port_ccw: return rx_ccw.size();
			default:              return rx_pe.size();
		endcase
	endfunction

	function automatic rx_t rx_pop(input router_pkg::port_e port);
		case (port)
			router_pkg::port_cw:  return rx_cw.pop_front();
			router_pkg::port_ccw: return rx_ccw.pop_front();
			default:              return rx_pe.pop_front();
		endcase
	endfunction

	function automatic router_pkg::flit_t make_flit(input logic dir, input logic [7:0] hop);
		router_pkg::flit_t f;
		f.hdr.vc       = 1'($urandom);
		f.hdr.dir      = dir;
		f.hdr.reserved = 6'($urandom);
		f.hdr.hop      = hop;
		f.hdr.payload  = {16'($urandom), $urandom};
		return f;
	endfunction

	// starts and returns at a falling edge and holds the flit until ready
	task automatic offer(input router_pkg::port_e port, input router_pkg::flit_t flit,
			output int unsigned accepted, output logic cls);
		router_pkg::link_t l;
		int                n;
		n = 0;
		l.send = 1'b1;
		l.data = flit;
		drive(port, l);
		while (!ready_of(port) && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!ready_of(port))
			report($sformatf("flit %h was never accepted on port %s", flit.raw, port.name()));
		accepted = cycle + 1;  // count right after the taking edge
		cls = polarity;
		@(negedge clk);
		drive(port, '0);
	endtask

	task automatic wait_rx(input router_pkg::port_e port, input int count, input string what);
		int n;
		n = 0;
		while (rx_size(port) < count && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (rx_size(port) < count)
			report($sformatf("%s never appeared within %0d cycles", what, wait_limit));
		@(negedge clk);
	endtask

	task automatic wait_polarity(input logic want);
		while (polarity !== want)
			@(negedge clk);
	endtask

	task automatic expect_flit(input router_pkg::port_e port, input router_pkg::flit_t want,
			input int unsigned acc, input int latency, input string name);
		rx_t item;
		wait_rx(port, 1, name);
		if (rx_size(port) > 0) begin
			item = rx_pop(port);
			check({name, ".data"}, item.flit, want);
			if (latency > 0)
				check({name, " latency"}, 64'(item.stamp - acc), 64'(latency));
		end
	endtask

	task automatic check_idle(input string name, input router_pkg::link_t link);
		check({name, ".send"}, 64'(link.send), 64'd0);
		check({name, ".data"}, link.data, 64'd0);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_reset_state();
		check_idle("cw_out", cw_out);
		check_idle("ccw_out", ccw_out);
		check_idle("pe_out", pe_out);
		check("cw_ready_out", 64'(cw_ready_out), 64'd1);
		check("ccw_ready_out", 64'(ccw_ready_out), 64'd1);
		check("pe_ready_out", 64'(pe_ready_out), 64'd1);
		for (int i = 0; i < 4; i++) begin
			check("polarity", 64'(polarity), 64'(i % 2));
			@(negedge clk);
		end
		finish_test("reset_state");
	endtask

	task automatic test_pass_through();
		router_pkg::flit_t f;
		router_pkg::flit_t want;
		int unsigned       acc;
		logic              cls;
		f = make_flit(1'b0, 8'd3);
		want = f;
		want.hdr.hop = 8'd2;  // one ring hop used
		offer(router_pkg::port_cw, f, acc, cls);
		expect_flit(router_pkg::port_cw, want, acc, 2, "cw_out");
		f = make_flit(1'b1, 8'd1);
		want = f;
		want.hdr.hop = 8'd0;
		offer(router_pkg::port_ccw, f, acc, cls);
		expect_flit(router_pkg::port_ccw, want, acc, 2, "ccw_out");
		finish_test("pass_through");
	endtask

	task automatic test_ejection();
		router_pkg::flit_t f;
		int unsigned       acc;
		logic              cls;
		f = make_flit(1'b0, 8'd0);
		offer(router_pkg::port_cw, f, acc, cls);
		expect_flit(router_pkg::port_pe, f, acc, 2, "pe_out");
		f = make_flit(1'b1, 8'd0);
		offer(router_pkg::port_ccw, f, acc, cls);
		expect_flit(router_pkg::port_pe, f, acc, 2, "pe_out");
		finish_test("ejection");
	endtask

	task automatic test_injection();
		router_pkg::flit_t f;
		router_pkg::flit_t want;
		int unsigned       acc;
		logic              cls;
		f = make_flit(1'b0, 8'd5);
		want = f;
		want.hdr.hop = 8'd4;
		offer(router_pkg::port_pe, f, acc, cls);
		expect_flit(router_pkg::port_cw, want, acc, 2, "cw_out");
		f = make_flit(1'b1, 8'd2);
		want = f;
		want.hdr.hop = 8'd1;
		offer(router_pkg::port_pe, f, acc, cls);
		expect_flit(router_pkg::port_ccw, want, acc, 2, "ccw_out");
		finish_test("injection");
	endtask

	task automatic test_contention();
		router_pkg::flit_t a;
		router_pkg::flit_t b;
		int unsigned       acc_a;
		int unsigned       acc_b;
		logic              cls_a;
		logic              cls_b;
		for (int round = 0; round < 2; round++) begin
			a = make_flit(1'b0, 8'd0);
			b = make_flit(1'b1, 8'd0);
			wait_polarity(1'b0);  // same class both rounds
			fork
				offer(router_pkg::port_cw, a, acc_a, cls_a);
				offer(router_pkg::port_ccw, b, acc_b, cls_b);
			join
			check("ccw acceptance cycle", 64'(acc_b), 64'(acc_a));
			// round-robin starts at cw after reset
			if (round == 0) begin
				expect_flit(router_pkg::port_pe, a, 0, 0, "pe_out first");
				expect_flit(router_pkg::port_pe, b, 0, 0, "pe_out second");
			end else begin
				expect_flit(router_pkg::port_pe, b, 0, 0, "pe_out first");
				expect_flit(router_pkg::port_pe, a, 0, 0, "pe_out second");
			end
		end
		finish_test("contention");
	endtask

	task automatic test_back_pressure();
		router_pkg::flit_t f;
		router_pkg::flit_t want;
		router_pkg::flit_t class0 [$];
		router_pkg::flit_t class1 [$];
		rx_t               item;
		int unsigned       acc;
		logic              cls;
		cw_ready_in = 1'b0;
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					f = make_flit(1'b0, 8'(i + 1));
					offer(router_pkg::port_cw, f, acc, cls);
					want = f;
					want.hdr.hop = f.hdr.hop - 8'd1;
					if (cls)
						class1.push_back(want);
					else
						class0.push_back(want);
				end
			end
			begin
				repeat (12) @(negedge clk);
				check("cw_out flits while blocked", 64'(rx_cw.size()), 64'd0);
				check("cw_ready_out", 64'(cw_ready_out), 64'd0);
				cw_ready_in = 1'b1;
			end
		join
		wait_rx(router_pkg::port_cw, 4, "released cw flits");
		repeat (6) @(negedge clk);  // time for a duplicate to show
		check("cw_out flit count", 64'(rx_cw.size()), 64'd4);
		while (rx_cw.size() > 0) begin
			item = rx_cw.pop_front();
			if (class0.size() > 0 && item.flit == class0[0])
				class0.delete(0);
			else if (class1.size() > 0 && item.flit == class1[0])
				class1.delete(0);
			else
				report($sformatf("cw_out flit %h is out of order or unexpected", item.flit.raw));
		end
		finish_test("back_pressure");
	endtask

	initial begin
		void'($urandom(83103));
		clk          = 1'b0;
		reset        = 1'b1;
		cw_in        = '0;
		ccw_in       = '0;
		pe_in        = '0;
		cw_ready_in  = 1'b1;
		ccw_ready_in = 1'b1;
		pe_ready_in  = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_pass_through();
		test_ejection();
		test_injection();
		test_contention();
		test_back_pressure();
		errors += UUT.u_assertions.fail_count;
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
